//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sram_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+.
mem_pkg.sv
axi_req_front.sv
sram_store.sv
axi_resp_back.sv
sram_axi_slave.sv
sram_props.sv
tb_clock.sv
tb_sram_checker.sv
tb_sram_top.sv

//--- axi_req_front.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_req_front (
	input  logic           clk,
	input  logic           rst,
	// read address channel
	input  logic           arvalid,
	input  mem_pkg::addr_t araddr,
	output logic           arready,
	// write address and data channels
	input  logic           awvalid,
	input  mem_pkg::addr_t awaddr,
	output logic           awready,
	input  logic           wvalid,
	input  mem_pkg::data_t wdata,
	input  mem_pkg::strb_t wstrb,
	output logic           wready,
	// slot status from the response side
	input  logic           r_free,
	input  logic           b_free,
	// read access to the store
	output logic           rd_en,
	output mem_pkg::idx_t  rd_idx,
	output logic           rd_fire,
	output logic           rd_err,
	// write access to the store
	output logic           wr_en,
	output mem_pkg::idx_t  wr_idx,
	output mem_pkg::data_t wr_data,
	output mem_pkg::strb_t wr_strb,
	output logic           wr_fire,
	output logic           wr_err
);
	import mem_pkg::*;

	// window size in bytes
	localparam addr_t WIN_BYTES = addr_t'(`MEM_WORDS * 8);

	addr_t ar_off;
	addr_t aw_off;
	logic  ar_hit;
	logic  aw_hit;
	logic  ar_acc;
	logic  aw_acc;

	// offset into the window, wraps for addresses below base
	assign ar_off = araddr - addr_t'(`MEM_BASE);
	assign aw_off = awaddr - addr_t'(`MEM_BASE);

	// below base wraps to a huge offset, so one compare covers both sides
	assign ar_hit = (ar_off < WIN_BYTES);
	assign aw_hit = (aw_off < WIN_BYTES);

	// ready follows the slot status
	assign arready = r_free;
	assign awready = b_free;
	// data phase is taken together with the address phase
	assign wready  = awready;

	// handshakes
	assign ar_acc = arvalid & arready;
	assign aw_acc = awvalid & wvalid & awready;

	// word index, low three bits are the byte lane and ignored
	assign rd_idx = ar_off[`IDX_W+2:3];
	assign wr_idx = aw_off[`IDX_W+2:3];

	// read strobes
	assign rd_fire = ar_acc;
	assign rd_err  = ~ar_hit;
	// no array access for a bad address
	assign rd_en   = ar_acc & ar_hit;

	// write strobes
	assign wr_fire = aw_acc;
	assign wr_err  = ~aw_hit;
	assign wr_en   = aw_acc & aw_hit;
	assign wr_data = wdata;
	assign wr_strb = wstrb;

endmodule

//--- axi_resp_back.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module axi_resp_back (
	input  logic           clk,
	input  logic           rst,
	// read side
	input  logic           rd_fire,
	input  logic           rd_err,
	input  mem_pkg::data_t rd_word,
	output logic           rvalid,
	output mem_pkg::data_t rdata,
	output mem_pkg::resp_t rresp,
	input  logic           rready,
	output logic           r_free,
	// write side
	input  logic           wr_fire,
	input  logic           wr_err,
	output logic           bvalid,
	output mem_pkg::resp_t bresp,
	input  logic           bready,
	output logic           b_free
);
	import mem_pkg::*;

	resp_state_t r_state;
	resp_state_t b_state;
	logic        r_err_q;
	logic        b_err_q;

	// slot update, same rule on both channels
	// a new fire wins over a take in the same cycle
	function automatic resp_state_t slot_next(resp_state_t cur, logic fire, logic take);
		resp_state_t nxt;
		nxt = cur;
		if (fire) begin
			nxt = resp_hold;
		end else if (take) begin
			nxt = resp_idle;
		end
		return nxt;
	endfunction

	// read slot
	always_ff @(posedge clk) begin
		if (rst) begin
			r_state <= resp_idle;
		end else begin
			r_state <= slot_next(r_state, rd_fire, rvalid & rready);
		end
	end

	// write slot
	always_ff @(posedge clk) begin
		if (rst) begin
			b_state <= resp_idle;
		end else begin
			b_state <= slot_next(b_state, wr_fire, bvalid & bready);
		end
	end

	// error flags ride along with the fire
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r_err_q <= rd_err;
		end
		if (wr_fire) begin
			b_err_q <= wr_err;
		end
	end

	assign rvalid = (r_state == resp_hold);
	assign bvalid = (b_state == resp_hold);

	// free when empty or being drained this cycle
	assign r_free = ~rvalid | rready;
	assign b_free = ~bvalid | bready;

	// bad reads return zero data
	assign rdata = r_err_q ? '0 : rd_word;
	assign rresp = r_err_q ? `RESP_SLVERR : `RESP_OKAY;
	assign bresp = b_err_q ? `RESP_SLVERR : `RESP_OKAY;

endmodule

//--- mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// byte address of word 0 in the slave window
`define MEM_BASE 32'h8000_0000

// depth of the word array
`define MEM_WORDS 256

// word index width, log2 of MEM_WORDS
`define IDX_W 8

// response codes on rresp and bresp
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif

//--- mem_pkg.sv
package mem_pkg;

	`include "mem_params.svh"

	// byte address on both address channels
	typedef logic [31:0] addr_t;

	// one data word
	typedef logic [63:0] data_t;

	// one strobe bit per byte of data_t
	typedef logic [7:0] strb_t;

	// word index into the array
	typedef logic [`IDX_W-1:0] idx_t;

	// okay or slverr
	typedef logic [1:0] resp_t;

	// response slot state, shared by read and write channels
	typedef enum logic {
		resp_idle,
		resp_hold
	} resp_state_t;

endpackage

//--- sram_axi_slave.sv
`timescale 1ns/1ps

module sram_axi_slave (
	input  logic           clk,
	input  logic           rst,
	// read address
	input  logic           arvalid,
	input  mem_pkg::addr_t araddr,
	output logic           arready,
	// read data
	output logic           rvalid,
	output mem_pkg::data_t rdata,
	output mem_pkg::resp_t rresp,
	input  logic           rready,
	// write address
	input  logic           awvalid,
	input  mem_pkg::addr_t awaddr,
	output logic           awready,
	// write data
	input  logic           wvalid,
	input  mem_pkg::data_t wdata,
	input  mem_pkg::strb_t wstrb,
	output logic           wready,
	// write response
	output logic           bvalid,
	output mem_pkg::resp_t bresp,
	input  logic           bready
);
	import mem_pkg::*;

	// front to back
	logic  r_free;
	logic  b_free;
	logic  rd_fire;
	logic  rd_err;
	logic  wr_fire;
	logic  wr_err;
	// front to store
	logic  rd_en;
	idx_t  rd_idx;
	logic  wr_en;
	idx_t  wr_idx;
	data_t wr_data;
	strb_t wr_strb;
	// store to back
	data_t rd_word;

	axi_req_front u_front (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.araddr  (araddr),
		.arready (arready),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.awready (awready),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wready  (wready),
		.r_free  (r_free),
		.b_free  (b_free),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_fire (rd_fire),
		.rd_err  (rd_err),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.wr_strb (wr_strb),
		.wr_fire (wr_fire),
		.wr_err  (wr_err)
	);

	sram_store u_store (
		.clk     (clk),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_word (rd_word),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.wr_strb (wr_strb)
	);

	axi_resp_back u_back (
		.clk     (clk),
		.rst     (rst),
		.rd_fire (rd_fire),
		.rd_err  (rd_err),
		.rd_word (rd_word),
		.rvalid  (rvalid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rready  (rready),
		.r_free  (r_free),
		.wr_fire (wr_fire),
		.wr_err  (wr_err),
		.bvalid  (bvalid),
		.bresp   (bresp),
		.bready  (bready),
		.b_free  (b_free)
	);

endmodule

//--- sram_props.sv
`timescale 1ns/1ps

module sram_props (
	input logic           clk,
	input logic           rst,
	input logic           rvalid,
	input logic           rready,
	input mem_pkg::data_t rdata,
	input mem_pkg::resp_t rresp,
	input logic           bvalid,
	input logic           bready,
	input mem_pkg::resp_t bresp
);
	// failure count, read by the testbench top
	int fails;

	// read response stays up until taken
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid)
		else begin
			fails++;
			$error("rvalid dropped before rready");
		end

	// read payload frozen during a stall
	a_r_stable: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> $stable(rdata) && $stable(rresp))
		else begin
			fails++;
			$error("rdata or rresp changed while the read response was stalled");
		end

	// write response held and frozen during a stall
	a_b_stable: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			fails++;
			$error("bvalid or bresp changed while the write response was stalled");
		end

endmodule

bind axi_resp_back sram_props u_props (
	.clk    (clk),
	.rst    (rst),
	.rvalid (rvalid),
	.rready (rready),
	.rdata  (rdata),
	.rresp  (rresp),
	.bvalid (bvalid),
	.bready (bready),
	.bresp  (bresp)
);

//--- sram_store.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module sram_store (
	input  logic           clk,
	// read port
	input  logic           rd_en,
	input  mem_pkg::idx_t  rd_idx,
	output mem_pkg::data_t rd_word,
	// write port with byte mask
	input  logic           wr_en,
	input  mem_pkg::idx_t  wr_idx,
	input  mem_pkg::data_t wr_data,
	input  mem_pkg::strb_t wr_strb
);
	import mem_pkg::*;

	// bytes per word, one strobe each
	localparam int NBYTES = $bits(strb_t);

	data_t mem [`MEM_WORDS];

	// byte-masked write
	// only lanes with a strobe set change
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < NBYTES; b++) begin
				if (wr_strb[b]) begin
					mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
				end
			end
		end
	end

	// registered read
	// samples the array before this edge's write lands,
	// so a same-cycle read at the write index sees the old word
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_word <= mem[rd_idx];
		end
	end

	// rd_word is left alone without rd_en
	// which keeps rdata steady while the master stalls

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);
	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset over the first 4 rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- tb_sram_checker.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_sram_checker (
	input  logic           clk,
	input  logic           rst,
	input  logic           arvalid,
	input  mem_pkg::addr_t araddr,
	input  logic           arready,
	input  logic           rvalid,
	input  mem_pkg::data_t rdata,
	input  mem_pkg::resp_t rresp,
	input  logic           rready,
	input  logic           awvalid,
	input  mem_pkg::addr_t awaddr,
	input  logic           awready,
	input  logic           wvalid,
	input  mem_pkg::data_t wdata,
	input  mem_pkg::strb_t wstrb,
	input  logic           wready,
	input  logic           bvalid,
	input  mem_pkg::resp_t bresp,
	input  logic           bready,
	output int             errors,
	output int             checks,
	output int             pending
);
	import mem_pkg::*;

	// name of the running test, set by the top
	string test_name;

	// shadow of the array, built from observed writes
	data_t shadow [`MEM_WORDS];
	data_t rd_q_data [$];
	resp_t rd_q_resp [$];
	resp_t wr_q_resp [$];

	// window is MEM_WORDS words of 8 bytes from MEM_BASE
	function automatic logic in_window(input addr_t a);
		addr_t off;
		off = a - addr_t'(`MEM_BASE);
		return off < addr_t'(`MEM_WORDS * 8);
	endfunction

	// byte offset divided by 8, kept to the index width
	function automatic idx_t word_index(input addr_t a);
		addr_t off;
		off = (a - addr_t'(`MEM_BASE)) >> 3;
		return idx_t'(off);
	endfunction

	// expected read result
	// called before the same edge's write is applied, so a colliding read sees the old word
	function automatic void expected_read(input addr_t a, output data_t d, output resp_t r);
		if (in_window(a)) begin
			d = shadow[word_index(a)];
			r = `RESP_OKAY;
		end else begin
			d = '0;
			r = `RESP_SLVERR;
		end
	endfunction

	always @(posedge clk) begin : compare
		data_t d;
		resp_t r;
		idx_t  wi;
		if (rst) begin
			errors = 0;
			checks = 0;
			rd_q_data.delete();
			rd_q_resp.delete();
			wr_q_resp.delete();
		end else begin
			// read response taken at this edge
			if (rvalid && rready) begin
				if (rd_q_data.size() == 0) begin
					errors++;
					$display("test %s: read response arrived with no read outstanding", test_name);
				end else begin
					d = rd_q_data.pop_front();
					r = rd_q_resp.pop_front();
					checks++;
					if (rdata !== d || rresp !== r) begin
						errors++;
						$display("[FAIL] %s read: expected %h resp %b, actual %h resp %b",
							test_name, d, r, rdata, rresp);
					end
				end
			end
			// write response taken at this edge
			if (bvalid && bready) begin
				if (wr_q_resp.size() == 0) begin
					errors++;
					$display("test %s: write response arrived with no write outstanding", test_name);
				end else begin
					r = wr_q_resp.pop_front();
					checks++;
					if (bresp !== r) begin
						errors++;
						$display("[FAIL] %s write: expected resp %b, actual resp %b",
							test_name, r, bresp);
					end
				end
			end
			// a stalled response blocks its request channel
			if (rvalid && !rready && arready) begin
				errors++;
				$display("test %s: arready was high while a read response was stalled", test_name);
			end
			if (bvalid && !bready && (awready || wready)) begin
				errors++;
				$display("test %s: awready or wready was high during a write stall", test_name);
			end
			// new read, looked up before the write below
			if (arvalid && arready) begin
				expected_read(araddr, d, r);
				rd_q_data.push_back(d);
				rd_q_resp.push_back(r);
			end
			// new write, out of range leaves the shadow alone
			if (awvalid && wvalid && awready) begin
				if (in_window(awaddr)) begin
					wi = word_index(awaddr);
					for (int b = 0; b < 8; b++) begin
						if (wstrb[b]) begin
							shadow[wi][b*8 +: 8] = wdata[b*8 +: 8];
						end
					end
					wr_q_resp.push_back(`RESP_OKAY);
				end else begin
					wr_q_resp.push_back(`RESP_SLVERR);
				end
			end
		end
		pending = rd_q_data.size() + wr_q_resp.size();
	end

endmodule

//--- tb_sram_top.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_sram_top;
	import mem_pkg::*;

	// transactions per test
	localparam int N_FULL  = 32;
	localparam int N_PART  = 3;
	localparam int N_RANGE = 6;
	localparam int N_STALL = 20;
	// 60 slots, each up to one read and one write
	localparam int N_MIX   = 120;
	localparam int MAX_CYCLES = 40 * (N_FULL + N_PART + N_RANGE + N_STALL + N_MIX) + 100;
	localparam addr_t BASE = `MEM_BASE;

	logic  clk;
	logic  rst;
	logic  arvalid;
	addr_t araddr;
	logic  arready;
	logic  rvalid;
	data_t rdata;
	resp_t rresp;
	logic  rready;
	logic  awvalid;
	addr_t awaddr;
	logic  awready;
	logic  wvalid;
	data_t wdata;
	strb_t wstrb;
	logic  wready;
	logic  bvalid;
	resp_t bresp;
	logic  bready;

	int   errors;
	int   checks;
	int   pending;
	int   seed;
	int   cycles;
	int   err_prev;
	int   chk_prev;
	logic stall_on;
	logic r_lvl;
	logic b_lvl;
	int   r_hold;
	int   b_hold;

	tb_clock u_clk (
		.clk (clk),
		.rst (rst)
	);

	sram_axi_slave uut (
		.clk (clk), .rst (rst),
		.arvalid (arvalid), .araddr (araddr), .arready (arready),
		.rvalid (rvalid), .rdata (rdata), .rresp (rresp), .rready (rready),
		.awvalid (awvalid), .awaddr (awaddr), .awready (awready),
		.wvalid (wvalid), .wdata (wdata), .wstrb (wstrb), .wready (wready),
		.bvalid (bvalid), .bresp (bresp), .bready (bready)
	);

	tb_sram_checker u_chk (
		.clk (clk), .rst (rst),
		.arvalid (arvalid), .araddr (araddr), .arready (arready),
		.rvalid (rvalid), .rdata (rdata), .rresp (rresp), .rready (rready),
		.awvalid (awvalid), .awaddr (awaddr), .awready (awready),
		.wvalid (wvalid), .wdata (wdata), .wstrb (wstrb), .wready (wready),
		.bvalid (bvalid), .bresp (bresp), .bready (bready),
		.errors (errors), .checks (checks), .pending (pending)
	);

	// pick ready levels at the falling edge, apply them at the rising edge
	always @(negedge clk) begin : ready_pick
		int t;
		if (r_hold == 0) begin
			t = $random(seed);
			r_lvl = t[4];
			r_hold = 1 + (t & 7);
		end else begin
			r_hold = r_hold - 1;
		end
		if (b_hold == 0) begin
			t = $random(seed);
			b_lvl = t[4];
			b_hold = 1 + (t & 7);
		end else begin
			b_hold = b_hold - 1;
		end
	end

	always @(posedge clk) begin
		rready <= stall_on ? r_lvl : 1'b1;
		bready <= stall_on ? b_lvl : 1'b1;
	end

	// run limit
	always @(posedge clk) begin : watchdog
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: no finish within %0d cycles, %0d responses outstanding",
				MAX_CYCLES, pending);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// one read, one write, or both in the same cycle
	// starts and ends on a rising edge
	task automatic issue(input logic do_rd, input addr_t ra, input logic do_wr,
		input addr_t wa, input data_t wd, input strb_t ws);
		logic rd_pend;
		logic wr_pend;
		logic rd_go;
		logic wr_go;
		rd_pend = do_rd;
		wr_pend = do_wr;
		if (do_rd) begin
			arvalid <= 1'b1;
			araddr  <= ra;
		end
		if (do_wr) begin
			awvalid <= 1'b1;
			wvalid  <= 1'b1;
			awaddr  <= wa;
			wdata   <= wd;
			wstrb   <= ws;
		end
		while (rd_pend || wr_pend) begin
			@(negedge clk);
			rd_go = rd_pend && arready;
			wr_go = wr_pend && awready && wready;
			@(posedge clk);
			if (rd_go) begin
				arvalid <= 1'b0;
				rd_pend = 1'b0;
			end
			if (wr_go) begin
				awvalid <= 1'b0;
				wvalid  <= 1'b0;
				wr_pend = 1'b0;
			end
		end
	endtask

	task automatic begin_test(input string name);
		u_chk.test_name <= name;
	endtask

	// wait until every response is back, then report the test
	task automatic end_test(input string name);
		do begin
			@(negedge clk);
		end while (pending != 0 || rvalid || bvalid);
		$display("test %s: %0d checks, %0d errors", name, checks - chk_prev, errors - err_prev);
		chk_prev = checks;
		err_prev = errors;
		@(posedge clk);
	endtask

	initial begin : main
		int    t;
		int    idx;
		int    prop_fails;
		int    reset_errs;
		logic  do_rd;
		logic  do_wr;
		addr_t ra;
		addr_t wa;
		arvalid  = 1'b0;
		araddr   = '0;
		awvalid  = 1'b0;
		awaddr   = '0;
		wvalid   = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		rready   = 1'b1;
		bready   = 1'b1;
		stall_on = 1'b0;
		r_hold   = 0;
		b_hold   = 0;
		cycles   = 0;
		err_prev = 0;
		chk_prev = 0;
		reset_errs = 0;
		seed     = 32'h94b5_fba5;
		@(negedge rst);

		// first cycle out of reset: both slots empty, all request channels open
		// bits are rvalid, bvalid, arready, awready, wready
		@(negedge clk);
		if ({rvalid, bvalid, arready, awready, wready} !== 5'b00111) begin
			reset_errs++;
			$display("[FAIL] reset_state: expected %b, actual %b",
				5'b00111, {rvalid, bvalid, arready, awready, wready});
		end
		$display("test reset_state: 1 checks, %0d errors", reset_errs);
		@(posedge clk);

		// words 0..15 get full-strobe data, later tests read them back
		begin_test("full_strobe");
		for (int i = 0; i < 16; i++) begin
			issue(1'b0, '0, 1'b1, BASE + addr_t'(i * 8), {$random(seed), $random(seed)}, 8'hff);
		end
		for (int i = 0; i < 16; i++) begin
			issue(1'b1, BASE + addr_t'(i * 8), 1'b0, '0, '0, '0);
		end
		end_test("full_strobe");

		begin_test("partial_strobe");
		issue(1'b0, '0, 1'b1, BASE + addr_t'(20 * 8), 64'h0123_4567_89ab_cdef, 8'hff);
		issue(1'b0, '0, 1'b1, BASE + addr_t'(20 * 8), 64'hffee_ddcc_bbaa_9988, 8'h10);
		issue(1'b1, BASE + addr_t'(20 * 8), 1'b0, '0, '0, '0);
		end_test("partial_strobe");

		// both bad addresses alias word 5
		begin_test("out_of_range");
		issue(1'b0, '0, 1'b1, BASE + addr_t'(5 * 8), 64'h5555_aaaa_5555_aaaa, 8'hff);
		issue(1'b0, '0, 1'b1, BASE - 32'h800 + addr_t'(5 * 8), 64'hdead_beef_dead_beef, 8'hff);
		issue(1'b0, '0, 1'b1, BASE + 32'h800 + addr_t'(5 * 8), 64'hbad0_bad0_bad0_bad0, 8'hff);
		issue(1'b1, BASE - 32'h800 + addr_t'(5 * 8), 1'b0, '0, '0, '0);
		issue(1'b1, BASE + 32'h800 + addr_t'(5 * 8), 1'b0, '0, '0, '0);
		issue(1'b1, BASE + addr_t'(5 * 8), 1'b0, '0, '0, '0);
		end_test("out_of_range");

		begin_test("back_pressure");
		stall_on <= 1'b1;
		for (int i = 0; i < N_STALL / 2; i++) begin
			t = $random(seed);
			idx = t & 15;
			issue(1'b0, '0, 1'b1, BASE + addr_t'(idx * 8), {$random(seed), $random(seed)}, 8'hff);
			issue(1'b1, BASE + addr_t'(idx * 8), 1'b0, '0, '0, '0);
		end
		end_test("back_pressure");

		// ready held high so read and write often land on the same edge
		begin_test("random_mix");
		stall_on <= 1'b0;
		for (int i = 0; i < N_MIX / 2; i++) begin
			t = $random(seed);
			do_rd = t[0] | ~t[1];
			do_wr = t[1];
			idx = (t >> 4) & 15;
			wa = BASE + addr_t'(idx * 8);
			if (t[2]) begin
				ra = wa;
			end else begin
				ra = BASE + addr_t'(((t >> 8) & 15) * 8);
			end
			issue(do_rd, ra, do_wr, wa, {$random(seed), $random(seed)}, strb_t'(t >> 16));
		end
		end_test("random_mix");

		prop_fails = uut.u_back.u_props.fails;
		$display("total: %0d checks, %0d errors, %0d assertion failures",
			checks + 1, errors + reset_errs, prop_fails);
		if (errors == 0 && reset_errs == 0 && prop_fails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
